// File: tb.f
mipsMemPkg.sv
DataMemory.sv
MemArbiter.sv
BlockCopy.sv
DataMemSystem.sv
tb_DataMemSystem.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the data memory testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_DataMemSystem -f tb.f -o simv

simOutput=$(./obj_dir/simv)
echo "$simOutput"

# Pass only when the testbench printed the pass line
if echo "$simOutput" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi

// File: tb_DataMemSystem.sv
`timescale 1ns/100ps

module tb_DataMemSystem;

    typedef logic [mipsMemPkg::DataWidth-1:0] word_t;

    localparam int ClockPeriod  = 4;
    localparam int NumWordTests = 16;   // Word writes followed by as many reads
    localparam int NumLaneWords = 4;    // Words touched by each lane test
    localparam int NumTraffic   = 24;   // Processor accesses during the shared copy
    localparam int MaxCopy      = 16;

    // Run budget from the test lengths
    localparam int CpuAccesses    = 3 * NumWordTests                 // Writes, reads, idle checks
                                  + 2 * NumLaneWords * 13            // Halfword and byte tests
                                  + MaxCopy + (MaxCopy + 1) + 2      // Block copy test
                                  + MaxCopy + NumTraffic + MaxCopy;  // Shared test
    localparam int CopiedWords    = 2 * MaxCopy;
    localparam int WatchdogCycles = 2 * (4 * CpuAccesses + 12 * CopiedWords);

    // Address regions kept apart so tests do not disturb each other
    localparam word_t CopySrcA   = 32'h0000_1000;
    localparam word_t CopyDstA   = 32'h0000_2000;
    localparam word_t IgnoredDst = 32'h0000_3000;  // Target of the start pulse sent while busy
    localparam word_t CopySrcB   = 32'h0000_1400;
    localparam word_t CopyDstB   = 32'h0000_2400;
    localparam word_t CpuRegion  = 32'h0000_3800;

    logic                               Clock;
    logic                               rst;
    word_t                              CpuAddress;
    word_t                              CpuWriteData;
    logic                               CpuMemRead;
    logic                               CpuMemWrite;
    logic [1:0]                         CpuByteSig;
    word_t                              CpuReadData;
    logic                               CpuStall;
    logic                               CopyStart;
    word_t                              CopySrc;
    word_t                              CopyDst;
    logic [mipsMemPkg::WordAddrWidth:0] CopyCount;
    logic                               CopyBusy;
    logic                               CopyDone;

    word_t  refMem [0:mipsMemPkg::MemWords-1];  // Reference copy of the data memory
    integer seed;
    int     errCount;
    int     testCount;
    int     failedTests;
    int     errAtStart;                         // Error count when the current test began
    mipsMemPkg::copyState_e copyState;

    assign copyState = u_dut.u_copy.state;

    DataMemSystem u_dut (
        .Clock       (Clock),
        .rst         (rst),
        .CpuAddress  (CpuAddress),
        .CpuWriteData(CpuWriteData),
        .CpuMemRead  (CpuMemRead),
        .CpuMemWrite (CpuMemWrite),
        .CpuByteSig  (CpuByteSig),
        .CpuReadData (CpuReadData),
        .CpuStall    (CpuStall),
        .CopyStart   (CopyStart),
        .CopySrc     (CopySrc),
        .CopyDst     (CopyDst),
        .CopyCount   (CopyCount),
        .CopyBusy    (CopyBusy),
        .CopyDone    (CopyDone)
    );

    initial begin
        Clock = 1'b0;
        forever begin
            #(ClockPeriod / 2) Clock = ~Clock;
        end
    end

    // At most one side stalled at a time
    assert property (@(posedge Clock) disable iff (rst) !(CpuStall && u_dut.copyStall))
        else begin
            $display("Stall check failed, CpuStall and CopyStall high in the same cycle");
            errCount++;
        end

    // No side loses twice in a row under round robin
    assert property (@(posedge Clock) disable iff (rst) !(CpuStall && $past(CpuStall)))
        else begin
            $display("Stall check failed, CpuStall high for two cycles in a row");
            errCount++;
        end
    assert property (@(posedge Clock) disable iff (rst)
                     !(u_dut.copyStall && $past(u_dut.copyStall)))
        else begin
            $display("Stall check failed, CopyStall high for two cycles in a row");
            errCount++;
        end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("Watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic word_t randomWordAddr(input word_t base, input word_t mask);
        word_t r;
        r = $random(seed);
        return base | (r & mask & 32'hffff_fffc);   // Always word aligned
    endfunction

    // Load result by the lane rules
    function automatic word_t expectedLoad(input word_t addr, input logic [1:0] size);
        word_t      w;
        logic [7:0] b;
        int         off;
        w   = refMem[addr[mipsMemPkg::WordAddrWidth+1:2]];
        off = int'(addr[1:0]);
        b   = w[8*off +: 8];
        expectedLoad = '0;                  // Misaligned halfword and code 11
        case (size)
            mipsMemPkg::AccWord: expectedLoad = w;
            mipsMemPkg::AccHalf: begin
                if (off == 0 || off == 2) begin
                    expectedLoad = {{16{w[8*off+15]}}, w[8*off +: 16]};
                end
            end
            mipsMemPkg::AccByte: expectedLoad = {{24{b[7]}}, b};
            default: ;
        endcase
    endfunction

    task automatic updateModel(input word_t addr, input word_t data, input logic [1:0] size);
        int idx;
        int off;
        idx = int'(addr[mipsMemPkg::WordAddrWidth+1:2]);
        off = int'(addr[1:0]);
        case (size)
            mipsMemPkg::AccWord: refMem[idx] = data;
            mipsMemPkg::AccHalf: begin
                if (off == 0 || off == 2) begin     // Misaligned store is dropped
                    refMem[idx][8*off +: 16] = data[15:0];
                end
            end
            mipsMemPkg::AccByte: refMem[idx][8*off +: 8] = data[7:0];
            default: ;
        endcase
    endtask

    // One processor access that returns once the result sits on CpuReadData
    task automatic issueAccess(input logic isWrite, input word_t addr, input word_t data,
                               input logic [1:0] size, output word_t result);
        @(posedge Clock);
        CpuAddress   <= addr;
        CpuWriteData <= data;
        CpuByteSig   <= size;
        CpuMemRead   <= !isWrite;
        CpuMemWrite  <= isWrite;
        @(negedge Clock);
        while (CpuStall) begin              // Request held unchanged
            @(negedge Clock);
        end
        @(posedge Clock);                   // Acceptance edge
        CpuMemRead  <= 1'b0;
        CpuMemWrite <= 1'b0;
        @(negedge Clock);
        result = CpuReadData;
    endtask

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic processorWrite(input word_t addr, input word_t data, input logic [1:0] size);
        word_t unused;
        issueAccess(1'b1, addr, data, size, unused);
        updateModel(addr, data, size);
    endtask

    task automatic readAndCompare(input string name, input word_t addr, input logic [1:0] size);
        word_t got;
        issueAccess(1'b0, addr, '0, size, got);
        checkValue(name, expectedLoad(addr, size), got);
    endtask

    task automatic startCopy(input word_t src, input word_t dst, input int count);
        @(posedge Clock);
        CopySrc   <= src;
        CopyDst   <= dst;
        CopyCount <= count[mipsMemPkg::WordAddrWidth:0];
        CopyStart <= 1'b1;
        @(posedge Clock);
        CopyStart <= 1'b0;                  // One-cycle pulse
    endtask

    // Waits for CopyBusy to fall and counts done pulses on the way
    task automatic waitCopyDone(input string name, input int count);
        int cycles;
        int pulses;
        cycles = 0;
        pulses = 0;
        do begin
            @(negedge Clock);
            cycles++;
            if (CopyDone) begin
                pulses++;
            end
        end while (CopyBusy && cycles < 12 * count + 8);
        assert (!CopyBusy) else begin
            $display("%s: copy did not finish in %0d cycles, engine stuck in %s",
                     name, cycles, copyState.name());
            errCount++;
        end
        assert (pulses == 1) else begin
            $display("** Error %s done pulses: expected 1, actual %0d", name, pulses);
            errCount++;
        end
    endtask

    task automatic copyInModel(input word_t src, input word_t dst, input int count);
        for (int i = 0; i < count; i++) begin
            refMem[dst[mipsMemPkg::WordAddrWidth+1:2] + i] =
                refMem[src[mipsMemPkg::WordAddrWidth+1:2] + i];
        end
    endtask

    task automatic finishTest(input string name);
        if (errCount == errAtStart) begin
            $display("Test %-12s passed", name);
        end else begin
            $display("Test %-12s failed with %0d errors", name, errCount - errAtStart);
            failedTests++;
        end
        testCount++;
        errAtStart = errCount;
    endtask

    task automatic resetTest();
        repeat (2) @(posedge Clock);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge Clock);
            assert (!CpuStall && !CopyBusy && !CopyDone && !u_dut.memRead && !u_dut.memWrite)
            else begin
                $display("reset_state: outputs not idle after reset, stall %b busy %b done %b",
                         CpuStall, CopyBusy, CopyDone);
                errCount++;
            end
        end
        finishTest("reset_state");
    endtask

    task automatic wordTest();
        word_t addrs [NumWordTests];
        word_t data;
        for (int i = 0; i < NumWordTests; i++) begin
            addrs[i] = randomWordAddr(32'h0, 32'h0fff);
            data     = $random(seed);
            processorWrite(addrs[i], data, mipsMemPkg::AccWord);
        end
        for (int i = 0; i < NumWordTests; i++) begin
            readAndCompare("word_rw", addrs[i], mipsMemPkg::AccWord);
            @(negedge Clock);               // Cycle with no read before this edge
            checkValue("word_idle", '0, CpuReadData);
        end
        finishTest("word_rw");
    endtask

    // Stores to each offset and loads back the lane and the whole word
    task automatic laneTest(input string name, input logic [1:0] size);
        word_t base;
        word_t data;
        for (int w = 0; w < NumLaneWords; w++) begin
            base = randomWordAddr(32'h0, 32'h0fff);
            data = $random(seed);
            processorWrite(base, data, mipsMemPkg::AccWord);   // Known background
            for (int off = 0; off < 4; off++) begin
                data     = $random(seed);
                data[15] = w[0] ^ off[0];   // Both signs for halfwords
                data[7]  = w[0] ^ off[1];   // And for bytes
                processorWrite(base + off, data, size);
                readAndCompare({name, "_load"}, base + off, size);
                readAndCompare({name, "_word"}, base, mipsMemPkg::AccWord);
            end
        end
        finishTest(name);
    endtask

    task automatic copyTest();
        int    count;
        word_t data;
        count = 1 + int'($unsigned($random(seed)) % MaxCopy);
        for (int i = 0; i < MaxCopy; i++) begin
            data = $random(seed);
            processorWrite(CopySrcA + 4 * i, data, mipsMemPkg::AccWord);
        end
        startCopy(CopySrcA, CopyDstA, count);
        @(negedge Clock);
        assert (CopyBusy) else begin
            $display("block_copy: CopyBusy did not rise after the start pulse");
            errCount++;
        end
        startCopy(CopySrcA, IgnoredDst, MaxCopy);   // Arrives while busy
        waitCopyDone("block_copy", count);
        copyInModel(CopySrcA, CopyDstA, count);
        for (int i = 0; i <= count; i++) begin     // One word past the run stays put
            readAndCompare("block_copy", CopyDstA + 4 * i, mipsMemPkg::AccWord);
        end
        readAndCompare("start_in_busy", IgnoredDst, mipsMemPkg::AccWord);
        readAndCompare("start_in_busy", IgnoredDst + 4, mipsMemPkg::AccWord);
        finishTest("block_copy");
    endtask

    task automatic sharedTest();
        word_t data;
        word_t addr;
        for (int i = 0; i < MaxCopy; i++) begin
            data = $random(seed);
            processorWrite(CopySrcB + 4 * i, data, mipsMemPkg::AccWord);
        end
        startCopy(CopySrcB, CopyDstB, MaxCopy);
        fork
            waitCopyDone("shared_copy", MaxCopy);
            begin
                for (int i = 0; i < NumTraffic; i++) begin
                    addr = randomWordAddr(CpuRegion, 32'h003f);  // Small window so reads hit writes
                    data = $random(seed);
                    if (data[0]) begin
                        processorWrite(addr, data, mipsMemPkg::AccWord);
                    end else begin
                        readAndCompare("shared_cpu", addr, mipsMemPkg::AccWord);
                    end
                end
            end
        join
        copyInModel(CopySrcB, CopyDstB, MaxCopy);
        for (int i = 0; i < MaxCopy; i++) begin
            readAndCompare("shared_copy", CopyDstB + 4 * i, mipsMemPkg::AccWord);
        end
        finishTest("shared");
    endtask

    initial begin
        seed         = 32'h11f0;
        errCount     = 0;
        testCount    = 0;
        failedTests  = 0;
        errAtStart   = 0;
        rst          = 1'b1;
        CpuAddress   = '0;
        CpuWriteData = '0;
        CpuMemRead   = 1'b0;
        CpuMemWrite  = 1'b0;
        CpuByteSig   = '0;
        CopyStart    = 1'b0;
        CopySrc      = '0;
        CopyDst      = '0;
        CopyCount    = '0;
        for (int i = 0; i < mipsMemPkg::MemWords; i++) begin
            refMem[i] = '0;                 // Memory starts cleared
        end
        resetTest();
        wordTest();
        laneTest("halfword", mipsMemPkg::AccHalf);
        laneTest("byte", mipsMemPkg::AccByte);
        copyTest();
        sharedTest();
        $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: DataMemSystem.sv
`timescale 1ns/100ps

module DataMemSystem (
    input  logic                                 Clock,
    input  logic                                 rst,
    // Processor load/store port
    input  logic [mipsMemPkg::DataWidth-1:0]     CpuAddress,
    input  logic [mipsMemPkg::DataWidth-1:0]     CpuWriteData,
    input  logic                                 CpuMemRead,
    input  logic                                 CpuMemWrite,
    input  logic [1:0]                           CpuByteSig,
    output logic [mipsMemPkg::DataWidth-1:0]     CpuReadData,
    output logic                                 CpuStall,
    // Copy control
    input  logic                                 CopyStart,
    input  logic [mipsMemPkg::DataWidth-1:0]     CopySrc,
    input  logic [mipsMemPkg::DataWidth-1:0]     CopyDst,
    input  logic [mipsMemPkg::WordAddrWidth:0]   CopyCount,
    output logic                                 CopyBusy,
    output logic                                 CopyDone
);

    // Copy engine to arbiter
    logic [mipsMemPkg::DataWidth-1:0] copyAddress;
    logic [mipsMemPkg::DataWidth-1:0] copyWriteData;
    logic                             copyMemRead;
    logic                             copyMemWrite;
    logic                             copyStall;

    // Arbiter to memory
    logic [mipsMemPkg::DataWidth-1:0] memAddress;
    logic [mipsMemPkg::DataWidth-1:0] memWriteData;
    logic                             memRead;
    logic                             memWrite;
    logic [1:0]                       memByteSig;

    MemArbiter u_arbiter (
        .Clock        (Clock),
        .rst          (rst),
        .CpuAddress   (CpuAddress),
        .CpuWriteData (CpuWriteData),
        .CpuMemRead   (CpuMemRead),
        .CpuMemWrite  (CpuMemWrite),
        .CpuByteSig   (CpuByteSig),
        .CopyAddress  (copyAddress),
        .CopyWriteData(copyWriteData),
        .CopyMemRead  (copyMemRead),
        .CopyMemWrite (copyMemWrite),
        .CpuStall     (CpuStall),
        .CopyStall    (copyStall),
        .MemAddress   (memAddress),
        .MemWriteData (memWriteData),
        .MemRead      (memRead),
        .MemWrite     (memWrite),
        .MemByteSig   (memByteSig)
    );

    // Read bus goes straight out as CpuReadData and back into the copy engine
    DataMemory u_memory (
        .Clock       (Clock),
        .MemAddress  (memAddress),
        .MemWriteData(memWriteData),
        .MemRead     (memRead),
        .MemWrite    (memWrite),
        .MemByteSig  (memByteSig),
        .ReadData    (CpuReadData)
    );

    BlockCopy u_copy (
        .Clock        (Clock),
        .rst          (rst),
        .CopyStart    (CopyStart),
        .CopySrc      (CopySrc),
        .CopyDst      (CopyDst),
        .CopyCount    (CopyCount),
        .CopyStall    (copyStall),
        .ReadData     (CpuReadData),   // Own data known from own grant
        .CopyAddress  (copyAddress),
        .CopyWriteData(copyWriteData),
        .CopyMemRead  (copyMemRead),
        .CopyMemWrite (copyMemWrite),
        .CopyBusy     (CopyBusy),
        .CopyDone     (CopyDone)
    );

endmodule

// File: BlockCopy.sv
`timescale 1ns/100ps

module BlockCopy (
    input  logic                                 Clock,
    input  logic                                 rst,
    input  logic                                 CopyStart,      // One-cycle pulse
    input  logic [mipsMemPkg::DataWidth-1:0]     CopySrc,        // Word-aligned source
    input  logic [mipsMemPkg::DataWidth-1:0]     CopyDst,        // Word-aligned destination
    input  logic [mipsMemPkg::WordAddrWidth:0]   CopyCount,      // Words to move
    input  logic                                 CopyStall,      // Request not granted
    input  logic [mipsMemPkg::DataWidth-1:0]     ReadData,       // Shared read bus
    output logic [mipsMemPkg::DataWidth-1:0]     CopyAddress,
    output logic [mipsMemPkg::DataWidth-1:0]     CopyWriteData,
    output logic                                 CopyMemRead,
    output logic                                 CopyMemWrite,
    output logic                                 CopyBusy,
    output logic                                 CopyDone
);

    mipsMemPkg::copyState_e                state;
    logic                                  readPending;  // Granted read, data due this cycle
    logic [mipsMemPkg::DataWidth-1:0]      srcAddr;
    logic [mipsMemPkg::DataWidth-1:0]      dstAddr;
    logic [mipsMemPkg::DataWidth-1:0]      dataReg;      // Word in flight
    logic [mipsMemPkg::WordAddrWidth:0]    wordsLeft;
    logic                                  lastWord;

    assign lastWord = (wordsLeft == {{mipsMemPkg::WordAddrWidth{1'b0}}, 1'b1});

    // Request lines held steady while stalled
    assign CopyAddress   = (state == mipsMemPkg::CopyWrite) ? dstAddr : srcAddr;
    assign CopyWriteData = dataReg;
    assign CopyMemRead   = (state == mipsMemPkg::CopyRead);
    assign CopyMemWrite  = (state == mipsMemPkg::CopyWrite) & ~readPending;

    assign CopyBusy = (state != mipsMemPkg::CopyIdle);
    assign CopyDone = (state == mipsMemPkg::CopyDone);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state       <= mipsMemPkg::CopyIdle;
            readPending <= 1'b0;
        end else begin
            case (state)
                mipsMemPkg::CopyIdle: begin
                    if (CopyStart) begin
                        srcAddr   <= CopySrc;
                        dstAddr   <= CopyDst;
                        wordsLeft <= CopyCount;
                        if (CopyCount == '0) begin
                            state <= mipsMemPkg::CopyDone;    // Nothing to move
                        end else begin
                            state <= mipsMemPkg::CopyRead;
                        end
                    end
                end
                mipsMemPkg::CopyRead: begin
                    if (!CopyStall) begin                     // Read granted this edge
                        readPending <= 1'b1;
                        state       <= mipsMemPkg::CopyWrite;
                    end
                end
                mipsMemPkg::CopyWrite: begin
                    if (readPending) begin
                        dataReg     <= ReadData;              // Source word arrives
                        readPending <= 1'b0;
                    end else if (!CopyStall) begin            // Write granted
                        srcAddr   <= srcAddr + 32'd4;
                        dstAddr   <= dstAddr + 32'd4;
                        wordsLeft <= wordsLeft - 1'b1;
                        if (lastWord) begin
                            state <= mipsMemPkg::CopyDone;
                        end else begin
                            state <= mipsMemPkg::CopyRead;
                        end
                    end
                end
                mipsMemPkg::CopyDone: begin
                    state <= mipsMemPkg::CopyIdle;            // Done pulse lasts one cycle
                end
                default: begin
                    state <= mipsMemPkg::CopyIdle;
                end
            endcase
        end
    end

endmodule

// File: MemArbiter.sv
`timescale 1ns/100ps

module MemArbiter (
    input  logic                             Clock,
    input  logic                             rst,
    // Processor request
    input  logic [mipsMemPkg::DataWidth-1:0] CpuAddress,
    input  logic [mipsMemPkg::DataWidth-1:0] CpuWriteData,
    input  logic                             CpuMemRead,
    input  logic                             CpuMemWrite,
    input  logic [1:0]                       CpuByteSig,
    // Copy engine request, always word sized
    input  logic [mipsMemPkg::DataWidth-1:0] CopyAddress,
    input  logic [mipsMemPkg::DataWidth-1:0] CopyWriteData,
    input  logic                             CopyMemRead,
    input  logic                             CopyMemWrite,
    output logic                             CpuStall,
    output logic                             CopyStall,
    // Shared memory port
    output logic [mipsMemPkg::DataWidth-1:0] MemAddress,
    output logic [mipsMemPkg::DataWidth-1:0] MemWriteData,
    output logic                             MemRead,
    output logic                             MemWrite,
    output logic [1:0]                       MemByteSig
);

    logic cpuReq;         // Processor asks this cycle
    logic copyReq;        // Copy engine asks this cycle
    logic grantCpu;
    logic grantCopy;
    logic lastGrantCopy;  // 1 when the copy engine won most recently

    assign cpuReq  = CpuMemRead | CpuMemWrite;
    assign copyReq = CopyMemRead | CopyMemWrite;

    // Copy wins alone, or on a tie when the processor had the last grant
    assign grantCopy = copyReq & (~cpuReq | ~lastGrantCopy);
    assign grantCpu  = cpuReq & ~grantCopy;

    assign CpuStall  = cpuReq & ~grantCpu;
    assign CopyStall = copyReq & ~grantCopy;

    // Winner steered onto the memory port
    assign MemAddress   = grantCopy ? CopyAddress : CpuAddress;
    assign MemWriteData = grantCopy ? CopyWriteData : CpuWriteData;
    assign MemRead      = grantCopy ? CopyMemRead : (grantCpu & CpuMemRead);
    assign MemWrite     = grantCopy ? CopyMemWrite : (grantCpu & CpuMemWrite);
    assign MemByteSig   = grantCopy ? mipsMemPkg::AccWord : CpuByteSig;

    // Round-robin history
    always_ff @(posedge Clock) begin
        if (rst) begin
            lastGrantCopy <= 1'b1;   // Processor is favoured first
        end else if (grantCpu) begin
            lastGrantCopy <= 1'b0;
        end else if (grantCopy) begin
            lastGrantCopy <= 1'b1;
        end
    end

endmodule

// File: DataMemory.sv
`timescale 1ns/100ps

module DataMemory (
    input  logic                             Clock,
    input  logic [mipsMemPkg::DataWidth-1:0] MemAddress,    // Byte address
    input  logic [mipsMemPkg::DataWidth-1:0] MemWriteData,
    input  logic                             MemRead,
    input  logic                             MemWrite,
    input  logic [1:0]                       MemByteSig,    // Access size code
    output logic [mipsMemPkg::DataWidth-1:0] ReadData       // Registered load result
);

    // Word storage
    logic [mipsMemPkg::DataWidth-1:0] memArray [0:mipsMemPkg::MemWords-1];

    logic [mipsMemPkg::WordAddrWidth-1:0] wordIndex;   // Address bits above the byte offset
    logic [1:0]                           byteOffset;  // Lane select within the word
    mipsMemPkg::accessSize_e              accessSize;
    logic [3:0]                           laneEnable;  // One bit per byte lane
    logic [mipsMemPkg::DataWidth-1:0]     laneData;    // Store data copied onto every lane
    logic [mipsMemPkg::DataWidth-1:0]     memWord;     // Addressed word before lane select
    logic [mipsMemPkg::DataWidth-1:0]     loadValue;   // Next ReadData when reading

    assign wordIndex  = MemAddress[mipsMemPkg::WordAddrWidth+1:2];
    assign byteOffset = MemAddress[1:0];
    assign accessSize = mipsMemPkg::accessSize_e'(MemByteSig);
    assign memWord    = memArray[wordIndex];

    // Memory comes up cleared
    initial begin
        for (int i = 0; i < mipsMemPkg::MemWords; i++) begin
            memArray[i] = '0;
        end
    end

    // Store lane decode
    always_comb begin
        laneEnable = 4'b0000;
        laneData   = MemWriteData;
        case (accessSize)
            mipsMemPkg::AccWord: begin
                laneEnable = 4'b1111;
            end
            mipsMemPkg::AccHalf: begin
                laneData = {2{MemWriteData[15:0]}};  // Halfword on both halves
                case (byteOffset)
                    2'b00:   laneEnable = 4'b0011;   // Lower half
                    2'b10:   laneEnable = 4'b1100;   // Upper half
                    default: laneEnable = 4'b0000;   // Misaligned, store dropped
                endcase
            end
            mipsMemPkg::AccByte: begin
                laneData   = {4{MemWriteData[7:0]}};
                laneEnable = 4'b0001 << byteOffset;
            end
            default: begin
                laneEnable = 4'b0000;                // Unused code
            end
        endcase
    end

    // Byte-lane store
    always_ff @(posedge Clock) begin
        if (MemWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (laneEnable[lane]) begin
                    memArray[wordIndex][8*lane +: 8] <= laneData[8*lane +: 8];
                end
            end
        end
    end

    // Load select with sign extension
    always_comb begin
        loadValue = '0;
        case (accessSize)
            mipsMemPkg::AccWord: begin
                loadValue = memWord;
            end
            mipsMemPkg::AccHalf: begin
                case (byteOffset)
                    2'b00:   loadValue = {{16{memWord[15]}}, memWord[15:0]};
                    2'b10:   loadValue = {{16{memWord[31]}}, memWord[31:16]};
                    default: loadValue = '0;   // Misaligned halfword reads zero
                endcase
            end
            mipsMemPkg::AccByte: begin
                case (byteOffset)
                    2'b00:   loadValue = {{24{memWord[7]}},  memWord[7:0]};
                    2'b01:   loadValue = {{24{memWord[15]}}, memWord[15:8]};
                    2'b10:   loadValue = {{24{memWord[23]}}, memWord[23:16]};
                    default: loadValue = {{24{memWord[31]}}, memWord[31:24]};
                endcase
            end
            default: begin
                loadValue = '0;
            end
        endcase
    end

    // Registered read port, zero on any edge without a read
    always_ff @(posedge Clock) begin
        if (MemRead) begin
            ReadData <= loadValue;
        end else begin
            ReadData <= '0;
        end
    end

endmodule

// File: mipsMemPkg.sv
package mipsMemPkg;

    // Memory geometry
    localparam int DataWidth     = 32;    // Word width, also the width of every data bus
    localparam int MemWords      = 4096;  // Words in the data memory
    localparam int WordAddrWidth = 12;    // Index into the word array

    // Access size carried on the ByteSig lines
    // Code 11 is not used and leaves memory untouched
    typedef enum logic [1:0] {
        AccWord = 2'b00,  // lw / sw
        AccHalf = 2'b01,  // lh / sh
        AccByte = 2'b10   // lb / sb
    } accessSize_e;

    // Copy engine states
    typedef enum logic [1:0] {
        CopyIdle  = 2'b00,  // Waiting for a start pulse
        CopyRead  = 2'b01,  // Source read requested
        CopyWrite = 2'b10,  // Data capture, then destination write
        CopyDone  = 2'b11   // One-cycle end marker
    } copyState_e;

endpackage
